// ==== verilog/controlPkg.sv ====
// opcode and enum encodings must match the assembler and datapath; fields are sized for a 16-bit datapath
`default_nettype none

package controlPkg;

   typedef enum logic [4:0] {
      ADD, ADDI, ADDIB, ADC, ADCI,
      SUB, SUBI, SUBIB, SUC, SUCI,
      NEG, CMP, CMPI,
      AND, OR, XOR, NOT, NAND, NOR,
      LSL, LSR, ASR,
      LUI, LLI,
      LDW, STW,
      BRANCH
   } opcode_t;                                      // 27 of 32 codes in use

   typedef enum logic [2:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branchCode_t;

   typedef struct packed {
      opcode_t     opcode;                          // bits 7:3
      branchCode_t branchCode;                      // bits 2:0, only read for BRANCH
   } instr_t;

   typedef enum logic [4:0] {
      FnA, FnADD, FnADC, FnSUB, FnSUC, FnNEG,
      FnAND, FnOR, FnXOR, FnNOT, FnNAND, FnNOR,
      FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFn_t;

   typedef enum logic {
      Op1Rd1, Op1Pc
   } op1Sel_t;

   typedef enum logic {
      Op2Imm, Op2Rd2
   } op2Sel_t;

   typedef enum logic {
      ImmShort, ImmLong
   } immSel_t;

   typedef enum logic [1:0] {
      Rs1Ra, Rs1Rd, Rs1Sp
   } rs1Sel_t;

   typedef enum logic {
      WdAlu, WdSys
   } wdSel_t;

   typedef enum logic {
      LrSys, LrPc
   } lrSel_t;

   typedef enum logic [1:0] {
      Pc1, PcAluOut, PcSysbus, PcInt
   } pcSel_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef enum logic [1:0] {
      Fetch, Execute, Interrupt
   } majorState_t;

   typedef enum logic [2:0] {
      Cycle0, Cycle1, Cycle2, Cycle3, Cycle4
   } subCycle_t;

   typedef struct packed {
      aluFn_t  aluOp;
      op1Sel_t op1Sel;
      op2Sel_t op2Sel;
      immSel_t immSel;
      rs1Sel_t rs1Sel;
      wdSel_t  wdSel;
      lrSel_t  lrSel;
      pcSel_t  pcSel;
      logic    aluEn;                               // alu result onto sysbus
      logic    aluWe;                               // alu output register load
      logic    lrEn;                                // link register onto sysbus
      logic    lrWe;
      logic    pcWe;
      logic    pcEn;                                // pc onto sysbus
      logic    irWe;
      logic    regWe;
   } datapathCtrl_t;

   typedef struct packed {
      logic memEn;                                  // pad direction control
      logic nWe;
      logic nOe;
      logic nMe;
      logic enb;
      logic ale;
   } busCtrl_t;

endpackage

`default_nettype wire

// ==== verilog/irqSync.sv ====
// nIrq is asynchronous and level sensitive; a pin still held low when intClear pulses raises a new request
`default_nettype none

module irqSync #(
   parameter int IrqSyncStages = 2
) (
   input  logic Clock,
   input  logic nReset,
   input  logic nIrq,
   input  logic intClear,
   output logic intReq
);

   logic [IrqSyncStages-1:0] syncChain;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         syncChain <= '0;
         intReq <= 1'b0;
      end else begin
         syncChain <= {syncChain[IrqSyncStages-2:0], ~nIrq};
         if (syncChain[IrqSyncStages-1])
            intReq <= 1'b1;                         // request wins over clear
         else if (intClear)
            intReq <= 1'b0;
      end
   end

   // the decoder only acknowledges a request that is pending
   clearOnlyWhenPending: assert property (
      @(posedge Clock) disable iff (!nReset)
      $rose(intClear) |-> intReq
   );

endmodule

`default_nettype wire

// ==== verilog/statusFlags.sv ====
// flags come straight from the ALU and are stored as one word; branch evaluation uses the stored copy only
`default_nettype none

module statusFlags (
   input  logic                    Clock,
   input  logic                    nReset,
   input  controlPkg::flags_t      flags,
   input  logic                    statusWe,
   input  controlPkg::branchCode_t branchCode,
   output logic                    branchTaken,
   output logic                    carryFlag
);

   controlPkg::flags_t status;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         status <= '0;
      else if (statusWe)
         status <= flags;                           // visible to the next instruction
   end

   assign carryFlag = status.c;

   always_comb begin
      case (branchCode)
         controlPkg::BR,
         controlPkg::BWL: branchTaken = 1'b1;
         controlPkg::BNE: branchTaken = ~status.z;
         controlPkg::BE:  branchTaken = status.z;
         controlPkg::BLT: branchTaken = status.n ^ status.v;
         controlPkg::BGE: branchTaken = ~(status.n ^ status.v);
         default:         branchTaken = 1'b0;      // RET and JMP are not conditional
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/cycleSequencer.sv ====
// never stalls; interrupts are sampled only in fetch Cycle0, so entry latency depends on the instruction mix
`default_nettype none

module cycleSequencer (
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic                    intReq,
   input  logic                    longOp,
   output controlPkg::majorState_t state,
   output controlPkg::subCycle_t   subCycle
);

   controlPkg::subCycle_t subCycleInc;

   assign subCycleInc = controlPkg::subCycle_t'(subCycle + 3'd1);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state <= controlPkg::Fetch;
         subCycle <= controlPkg::Cycle0;
      end else begin
         case (state)
            controlPkg::Fetch: begin
               if (subCycle == controlPkg::Cycle0 && intReq) begin
                  state <= controlPkg::Interrupt;   // sub-cycle stays at Cycle0
               end else if (subCycle == controlPkg::Cycle3) begin
                  state <= controlPkg::Execute;
                  subCycle <= controlPkg::Cycle0;
               end else begin
                  subCycle <= subCycleInc;
               end
            end
            controlPkg::Execute: begin
               if (subCycle == controlPkg::Cycle4 ||
                   (subCycle == controlPkg::Cycle0 && !longOp)) begin
                  state <= controlPkg::Fetch;
                  subCycle <= controlPkg::Cycle0;
               end else begin
                  subCycle <= subCycleInc;
               end
            end
            default: begin                          // interrupt entry
               if (subCycle == controlPkg::Cycle4) begin
                  state <= controlPkg::Fetch;
                  subCycle <= controlPkg::Cycle0;
               end else begin
                  subCycle <= subCycleInc;
               end
            end
         endcase
      end
   end

   fetchNoCycle4: assert property (
      @(posedge Clock) disable iff (!nReset)
      state == controlPkg::Fetch |-> subCycle != controlPkg::Cycle4
   );

   // only a memory instruction stays in execute past Cycle0
   longOpLeavesCycle0: assert property (
      @(posedge Clock) disable iff (!nReset)
      (state == controlPkg::Execute && subCycle == controlPkg::Cycle1) |-> $past(longOp)
   );

endmodule

`default_nettype wire

// ==== verilog/controlDecoder.sv ====
// purely combinational; undefined opcodes decode as FnA ALU ops, and memory is written while nWe is low
`default_nettype none

module controlDecoder (
   input  controlPkg::majorState_t   state,
   input  controlPkg::subCycle_t     subCycle,
   input  controlPkg::instr_t        instr,
   input  logic                      branchTaken,
   output controlPkg::datapathCtrl_t datapath,
   output controlPkg::busCtrl_t      bus,
   output logic                      longOp,
   output logic                      statusWe,
   output logic                      intClear
);

   logic isLoad;
   logic isStore;
   logic memCycle;

   function automatic controlPkg::aluFn_t aluFnOf(input controlPkg::opcode_t op);
      case (op)
         controlPkg::ADD, controlPkg::ADDI, controlPkg::ADDIB: aluFnOf = controlPkg::FnADD;
         controlPkg::ADC, controlPkg::ADCI:                    aluFnOf = controlPkg::FnADC;
         controlPkg::SUB, controlPkg::SUBI, controlPkg::SUBIB,
         controlPkg::CMP, controlPkg::CMPI:                    aluFnOf = controlPkg::FnSUB;
         controlPkg::SUC, controlPkg::SUCI:                    aluFnOf = controlPkg::FnSUC;
         controlPkg::NEG:                                      aluFnOf = controlPkg::FnNEG;
         controlPkg::AND:                                      aluFnOf = controlPkg::FnAND;
         controlPkg::OR:                                       aluFnOf = controlPkg::FnOR;
         controlPkg::XOR:                                      aluFnOf = controlPkg::FnXOR;
         controlPkg::NOT:                                      aluFnOf = controlPkg::FnNOT;
         controlPkg::NAND:                                     aluFnOf = controlPkg::FnNAND;
         controlPkg::NOR:                                      aluFnOf = controlPkg::FnNOR;
         controlPkg::LSL:                                      aluFnOf = controlPkg::FnLSL;
         controlPkg::LSR:                                      aluFnOf = controlPkg::FnLSR;
         controlPkg::ASR:                                      aluFnOf = controlPkg::FnASR;
         controlPkg::LUI:                                      aluFnOf = controlPkg::FnLUI;
         controlPkg::LLI:                                      aluFnOf = controlPkg::FnLLI;
         default:                                              aluFnOf = controlPkg::FnA;
      endcase
   endfunction

   assign isLoad = instr.opcode == controlPkg::LDW;
   assign isStore = instr.opcode == controlPkg::STW;
   assign longOp = state == controlPkg::Execute && subCycle == controlPkg::Cycle0 &&
                   (isLoad || isStore);

   always_comb begin
      datapath = '0;                                // FnA, Rd1, Op2Imm, Rs1Ra, WdAlu, LrSys, Pc1
      datapath.immSel = controlPkg::ImmLong;
      bus = '0;
      bus.nMe = 1'b1;
      statusWe = 1'b0;
      intClear = 1'b0;
      case (state)
         controlPkg::Fetch: begin
            bus.nWe = 1'b1;
            case (subCycle)
               controlPkg::Cycle0: begin
                  bus.ale = 1'b1;
                  bus.nOe = 1'b1;
                  datapath.pcEn = 1'b1;
               end
               controlPkg::Cycle1: begin
                  bus.nMe = 1'b0;
                  bus.memEn = 1'b1;
               end
               controlPkg::Cycle2: begin
                  bus.nMe = 1'b0;
                  bus.memEn = 1'b1;
                  bus.enb = 1'b1;
               end
               default: begin
                  bus.memEn = 1'b1;
                  datapath.irWe = 1'b1;
               end
            endcase
         end
         controlPkg::Execute: begin
            case (subCycle)
               controlPkg::Cycle0: begin
                  if (isLoad || isStore) begin      // effective address into alu register
                     datapath.aluOp = controlPkg::FnADD;
                     datapath.immSel = controlPkg::ImmShort;
                     datapath.aluEn = 1'b1;
                     datapath.aluWe = 1'b1;
                  end else if (instr.opcode == controlPkg::BRANCH) begin
                     datapath.pcWe = 1'b1;
                     case (instr.branchCode)
                        controlPkg::RET: begin
                           datapath.lrEn = 1'b1;
                           datapath.pcSel = controlPkg::PcSysbus;
                        end
                        controlPkg::JMP: begin
                           datapath.aluOp = controlPkg::FnADD;
                           datapath.immSel = controlPkg::ImmShort;
                           datapath.pcSel = controlPkg::PcAluOut;
                        end
                        default: begin              // pc relative, long offset
                           datapath.aluOp = controlPkg::FnADD;
                           datapath.op1Sel = controlPkg::Op1Pc;
                           datapath.aluEn = 1'b1;
                           if (branchTaken) begin
                              datapath.pcSel = controlPkg::PcAluOut;
                              if (instr.branchCode == controlPkg::BWL) begin
                                 datapath.lrWe = 1'b1;
                                 datapath.lrSel = controlPkg::LrPc;
                              end
                           end
                        end
                     endcase
                  end else begin
                     datapath.aluOp = aluFnOf(instr.opcode);
                     datapath.pcEn = 1'b1;
                     datapath.pcWe = 1'b1;
                     datapath.regWe = instr.opcode != controlPkg::CMP &&
                                      instr.opcode != controlPkg::CMPI;
                     case (instr.opcode)
                        controlPkg::ADD, controlPkg::ADC, controlPkg::SUB, controlPkg::SUC,
                        controlPkg::CMP, controlPkg::AND, controlPkg::OR, controlPkg::XOR,
                        controlPkg::NAND, controlPkg::NOR:
                           datapath.op2Sel = controlPkg::Op2Rd2;
                        controlPkg::ADDI, controlPkg::ADCI, controlPkg::SUBI, controlPkg::SUCI,
                        controlPkg::CMPI, controlPkg::LSL, controlPkg::LSR, controlPkg::ASR:
                           datapath.immSel = controlPkg::ImmShort;
                        controlPkg::ADDIB, controlPkg::SUBIB:
                           datapath.rs1Sel = controlPkg::Rs1Rd;
                        default: begin
                           datapath.rs1Sel = controlPkg::Rs1Rd;
                           datapath.aluEn = 1'b1;
                        end
                     endcase
                     // immediate loads leave the flags alone
                     statusWe = instr.opcode != controlPkg::LUI &&
                                instr.opcode != controlPkg::LLI;
                  end
               end
               controlPkg::Cycle1: begin            // address out
                  bus.ale = 1'b1;
                  bus.nWe = 1'b1;
                  bus.nOe = 1'b1;
                  datapath.aluOp = controlPkg::FnADD;
                  datapath.immSel = controlPkg::ImmShort;
                  datapath.aluEn = 1'b1;
               end
               controlPkg::Cycle2: begin
                  bus.nMe = 1'b0;
                  bus.nWe = 1'b1;
                  bus.memEn = isLoad;
                  bus.nOe = isStore;
                  datapath.rs1Sel = controlPkg::Rs1Rd;  // store data passes through the alu
                  datapath.aluEn = 1'b1;
                  datapath.aluWe = 1'b1;
               end
               controlPkg::Cycle3: begin
                  bus.nMe = 1'b0;
                  bus.memEn = isLoad;
                  bus.enb = isLoad;
                  bus.nWe = isLoad;                 // store writes here
                  bus.nOe = isStore;
                  datapath.aluEn = isStore;
               end
               default: begin
                  datapath.pcWe = 1'b1;
                  bus.nWe = isLoad;
                  bus.memEn = isLoad;
                  bus.nOe = isStore;
                  datapath.aluEn = isStore;
                  datapath.regWe = isLoad;
                  if (isLoad)
                     datapath.wdSel = controlPkg::WdSys;
               end
            endcase
         end
         default: begin                             // push pc at sp, then vector
            bus.nOe = subCycle != controlPkg::Cycle0;
            case (subCycle)
               controlPkg::Cycle0: begin
                  datapath.rs1Sel = controlPkg::Rs1Sp;
                  datapath.aluEn = 1'b1;
                  datapath.aluWe = 1'b1;
               end
               controlPkg::Cycle1: begin
                  datapath.rs1Sel = controlPkg::Rs1Sp;
                  datapath.aluEn = 1'b1;
                  bus.ale = 1'b1;
                  bus.nWe = 1'b1;
               end
               controlPkg::Cycle2: begin
                  bus.nMe = 1'b0;
                  bus.nWe = 1'b1;
                  datapath.pcEn = 1'b1;
               end
               controlPkg::Cycle3: begin
                  bus.nMe = 1'b0;
                  datapath.pcEn = 1'b1;
               end
               default: begin
                  datapath.pcEn = 1'b1;
                  datapath.pcWe = 1'b1;
                  datapath.pcSel = controlPkg::PcInt;
                  intClear = 1'b1;
               end
            endcase
         end
      endcase
   end

   assign memCycle = (state == controlPkg::Fetch &&
                      (subCycle == controlPkg::Cycle1 || subCycle == controlPkg::Cycle2)) ||
                     (state != controlPkg::Fetch &&
                      (subCycle == controlPkg::Cycle2 || subCycle == controlPkg::Cycle3));

   memSelectInMemCycle: assert final (bus.nMe || memCycle);

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
// drives a separate datapath and memory; instr and flags must be stable from mid-cycle to the rising edge
`default_nettype none

module controlUnit #(
   parameter int IrqSyncStages = 2                  // 2 or more
) (
   input  logic                      Clock,
   input  logic                      nReset,
   input  controlPkg::instr_t        instr,
   input  controlPkg::flags_t        flags,
   input  logic                      nIrq,
   output controlPkg::datapathCtrl_t datapath,
   output controlPkg::busCtrl_t      bus,
   output logic                      carryFlag
);

   controlPkg::majorState_t state;
   controlPkg::subCycle_t   subCycle;
   logic                    longOp;
   logic                    intReq;
   logic                    intClear;
   logic                    statusWe;
   logic                    branchTaken;

   irqSync #(
      .IrqSyncStages(IrqSyncStages)
   ) irqSyncI (
      .Clock(Clock),
      .nReset(nReset),
      .nIrq(nIrq),
      .intClear(intClear),
      .intReq(intReq)
   );

   statusFlags statusFlagsI (
      .Clock(Clock),
      .nReset(nReset),
      .flags(flags),
      .statusWe(statusWe),
      .branchCode(instr.branchCode),
      .branchTaken(branchTaken),
      .carryFlag(carryFlag)
   );

   cycleSequencer cycleSequencerI (
      .Clock(Clock),
      .nReset(nReset),
      .intReq(intReq),
      .longOp(longOp),
      .state(state),
      .subCycle(subCycle)
   );

   controlDecoder controlDecoderI (
      .state(state),
      .subCycle(subCycle),
      .instr(instr),
      .branchTaken(branchTaken),
      .datapath(datapath),
      .bus(bus),
      .longOp(longOp),
      .statusWe(statusWe),
      .intClear(intClear)
   );

endmodule

`default_nettype wire

// ==== verification/controlUnitTb.sv ====
// expects IrqSyncStages = 2; each branch row reads the flags that the CMP row right before it loaded
`default_nettype none

module controlUnitTb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      controlPkg::instr_t  instr;
      controlPkg::flags_t  flags;                   // driven while the row executes
      controlPkg::aluFn_t  aluOp;
      logic                regWe;
      controlPkg::pcSel_t  pcSel;
      logic                lrWe;
      int                  spacing;                 // cycles from this row's irWe to the next
   } row_t;

   logic                      Clock;
   logic                      nReset;
   controlPkg::instr_t        instr;
   controlPkg::flags_t        flags;
   logic                      nIrq;
   controlPkg::datapathCtrl_t datapath;
   controlPkg::busCtrl_t      bus;
   logic                      carryFlag;

   integer                    seed = 36;
   row_t                      rows[$];
   row_t                      row;
   controlPkg::datapathCtrl_t want;
   controlPkg::datapathCtrl_t mask;
   controlPkg::datapathCtrl_t rowMask;
   controlPkg::busCtrl_t      busWant;
   controlPkg::busCtrl_t      busMask;
   int                        count;
   int                        extraEntries;
   logic                      isLong;
   logic                      carryWant;

   controlUnit #(
      .IrqSyncStages(2)
   ) dut (
      .Clock(Clock),
      .nReset(nReset),
      .instr(instr),
      .flags(flags),
      .nIrq(nIrq),
      .datapath(datapath),
      .bus(bus),
      .carryFlag(carryFlag)
   );

   always #2 Clock = ~Clock;                        // 4 ns period

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic nextCycle();
      @(negedge Clock);                             // outputs settled, inputs change here
   endtask

   task automatic checkDatapath(input controlPkg::datapathCtrl_t got,
                                input controlPkg::datapathCtrl_t expected,
                                input controlPkg::datapathCtrl_t fields,
                                input string what);
      if (((got ^ expected) & fields) != '0)
         stopRun($sformatf("FAILED at %0t ns: %s, datapath %h expected %h in fields %h",
                           $time, what, got, expected, fields));
   endtask

   task automatic checkBus(input controlPkg::busCtrl_t got,
                           input controlPkg::busCtrl_t expected,
                           input controlPkg::busCtrl_t fields,
                           input string what);
      if (((got ^ expected) & fields) != '0)
         stopRun($sformatf("FAILED at %0t ns: %s, bus %b expected %b in fields %b",
                           $time, what, got, expected, fields));
   endtask

   task automatic checkCount(input int got, input int expected, input string what);
      if (got != expected)
         stopRun($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
                           $time, what, got, expected));
   endtask

   task automatic waitIrWe(output int cycles, input int limit, input string what);
      cycles = 0;
      do begin
         nextCycle();
         cycles++;
      end while (!datapath.irWe && cycles < limit);
      if (!datapath.irWe)
         stopRun($sformatf("timeout: no irWe pulse within %0d cycles %s", limit, what));
   endtask

   // branch rules of the status register
   function automatic logic conditionHolds(input controlPkg::flags_t f,
                                           input controlPkg::branchCode_t code);
      case (code)
         controlPkg::BR,
         controlPkg::BWL: conditionHolds = 1'b1;
         controlPkg::BNE: conditionHolds = !f.z;
         controlPkg::BE:  conditionHolds = f.z;
         controlPkg::BLT: conditionHolds = f.n != f.v;
         controlPkg::BGE: conditionHolds = f.n == f.v;
         default:         conditionHolds = 1'b0;
      endcase
   endfunction

   task automatic addRow(input controlPkg::opcode_t op, input controlPkg::branchCode_t code,
                         input controlPkg::aluFn_t fn, input logic regWe,
                         input controlPkg::pcSel_t pcSel, input logic lrWe, input int spacing);
      row_t        r;
      logic [31:0] rnd;
      rnd = $random(seed);
      r.instr.opcode = op;
      r.instr.branchCode = code;
      r.flags = controlPkg::flags_t'(rnd[3:0]);
      r.aluOp = fn;
      r.regWe = regWe;
      r.pcSel = pcSel;
      r.lrWe = lrWe;
      r.spacing = spacing;
      rows.push_back(r);
   endtask

   task automatic addAlu(input controlPkg::opcode_t op, input controlPkg::aluFn_t fn,
                         input logic regWe);
      logic [31:0] rnd;
      rnd = $random(seed);                          // low bits are don't care outside BRANCH
      addRow(op, controlPkg::branchCode_t'(rnd[2:0]), fn, regWe, controlPkg::Pc1, 1'b0, 5);
   endtask

   task automatic addCmpBranch(input controlPkg::branchCode_t code);
      logic taken;
      addRow(controlPkg::CMP, code, controlPkg::FnSUB, 1'b0, controlPkg::Pc1, 1'b0, 5);
      taken = conditionHolds(rows[$].flags, code);
      addRow(controlPkg::BRANCH, code, controlPkg::FnADD, 1'b0,
             taken ? controlPkg::PcAluOut : controlPkg::Pc1,
             taken && code == controlPkg::BWL, 5);
   endtask

   task automatic buildRows();
      logic [31:0] rnd;
      int          pick;
      addAlu(controlPkg::ADD, controlPkg::FnADD, 1'b1);
      addAlu(controlPkg::ADDI, controlPkg::FnADD, 1'b1);
      addAlu(controlPkg::ADDIB, controlPkg::FnADD, 1'b1);
      addAlu(controlPkg::ADC, controlPkg::FnADC, 1'b1);
      addAlu(controlPkg::ADCI, controlPkg::FnADC, 1'b1);
      addAlu(controlPkg::SUB, controlPkg::FnSUB, 1'b1);
      addAlu(controlPkg::SUBI, controlPkg::FnSUB, 1'b1);
      addAlu(controlPkg::SUBIB, controlPkg::FnSUB, 1'b1);
      addAlu(controlPkg::SUC, controlPkg::FnSUC, 1'b1);
      addAlu(controlPkg::SUCI, controlPkg::FnSUC, 1'b1);
      addAlu(controlPkg::NEG, controlPkg::FnNEG, 1'b1);
      addAlu(controlPkg::CMP, controlPkg::FnSUB, 1'b0);
      addAlu(controlPkg::CMPI, controlPkg::FnSUB, 1'b0);
      addAlu(controlPkg::AND, controlPkg::FnAND, 1'b1);
      addAlu(controlPkg::OR, controlPkg::FnOR, 1'b1);
      addAlu(controlPkg::XOR, controlPkg::FnXOR, 1'b1);
      addAlu(controlPkg::NOT, controlPkg::FnNOT, 1'b1);
      addAlu(controlPkg::NAND, controlPkg::FnNAND, 1'b1);
      addAlu(controlPkg::NOR, controlPkg::FnNOR, 1'b1);
      addAlu(controlPkg::LSL, controlPkg::FnLSL, 1'b1);
      addAlu(controlPkg::LSR, controlPkg::FnLSR, 1'b1);
      addAlu(controlPkg::ASR, controlPkg::FnASR, 1'b1);
      addAlu(controlPkg::LUI, controlPkg::FnLUI, 1'b1);
      addAlu(controlPkg::LLI, controlPkg::FnLLI, 1'b1);
      // address add in execute Cycle0, then four memory cycles
      addRow(controlPkg::LDW, controlPkg::BR, controlPkg::FnADD, 1'b0, controlPkg::Pc1, 1'b0, 9);
      addRow(controlPkg::STW, controlPkg::BR, controlPkg::FnADD, 1'b0, controlPkg::Pc1, 1'b0, 9);
      for (int c = 0; c < 6; c++)
         addCmpBranch(controlPkg::branchCode_t'(c));
      repeat (6) begin
         rnd = $random(seed);
         pick = rnd % 32'd6;                        // BR up to BWL
         addCmpBranch(controlPkg::branchCode_t'(pick[2:0]));
      end
      addRow(controlPkg::BRANCH, controlPkg::RET, controlPkg::FnA, 1'b0,
             controlPkg::PcSysbus, 1'b0, 5);
      addRow(controlPkg::BRANCH, controlPkg::JMP, controlPkg::FnADD, 1'b0,
             controlPkg::PcAluOut, 1'b0, 5);
   endtask

   task automatic checkMemExit(input logic isLoad, input int index);
      controlPkg::datapathCtrl_t expected;
      controlPkg::datapathCtrl_t fields;
      controlPkg::busCtrl_t      busExpected;
      controlPkg::busCtrl_t      busFields;
      expected = '0;
      fields = '0;
      expected.regWe = isLoad;
      fields.regWe = 1'b1;
      if (isLoad) begin
         expected.wdSel = controlPkg::WdSys;        // loaded word comes off the bus
         fields.wdSel = controlPkg::wdSel_t'(1'b1);
      end
      checkDatapath(datapath, expected, fields, $sformatf("row %0d last execute cycle", index));
      if (!isLoad) begin
         busExpected = '0;
         busFields = '0;
         busExpected.nOe = 1'b1;
         busFields.nOe = 1'b1;
         checkBus(bus, busExpected, busFields, $sformatf("row %0d store exit", index));
      end
   endtask

   initial begin
      Clock = 1'b0;
      nReset = 1'b0;
      nIrq = 1'b1;
      instr.opcode = controlPkg::ADD;
      instr.branchCode = controlPkg::BR;
      flags = '0;
      carryWant = 1'b0;
      buildRows();
      rowMask = '0;
      rowMask.aluOp = controlPkg::aluFn_t'(5'h1f);
      rowMask.pcSel = controlPkg::pcSel_t'(2'h3);
      rowMask.regWe = 1'b1;
      rowMask.lrWe = 1'b1;
      rowMask.pcWe = 1'b1;
      rowMask.lrEn = 1'b1;

      repeat (4) @(posedge Clock);
      nextCycle();
      busWant = '0;
      busWant.ale = 1'b1;
      busWant.nWe = 1'b1;
      busWant.nOe = 1'b1;
      busWant.nMe = 1'b1;
      busMask = '1;
      checkBus(bus, busWant, busMask, "bus in reset");
      want = '0;
      want.pcEn = 1'b1;
      mask = '0;
      mask.pcEn = 1'b1;
      mask.irWe = 1'b1;
      mask.regWe = 1'b1;
      mask.pcWe = 1'b1;
      mask.lrWe = 1'b1;
      mask.aluWe = 1'b1;
      checkDatapath(datapath, want, mask, "datapath in reset");
      checkCount(int'(dut.statusWe), 0, "statusWe in reset");
      checkCount(int'(carryFlag), 0, "carryFlag in reset");
      nReset = 1'b1;                                // this half cycle is fetch Cycle0
      waitIrWe(count, 10, "after reset release");
      checkCount(count, 3, "cycles from reset release to first irWe");

      foreach (rows[i]) begin
         row = rows[i];
         instr = row.instr;
         flags = row.flags;
         isLong = row.instr.opcode == controlPkg::LDW || row.instr.opcode == controlPkg::STW;
         nextCycle();
         want = '0;
         want.aluOp = row.aluOp;
         want.regWe = row.regWe;
         want.pcSel = row.pcSel;
         want.lrWe = row.lrWe;
         want.pcWe = !isLong;
         want.lrEn = row.instr.opcode == controlPkg::BRANCH &&
                     row.instr.branchCode == controlPkg::RET;
         checkDatapath(datapath, want, rowMask,
                       $sformatf("row %0d %s execute Cycle0", i, row.instr.opcode.name()));
         if (row.instr.opcode == controlPkg::BRANCH)
            checkCount(int'(carryFlag), int'(carryWant),
                       $sformatf("row %0d stored carry", i));
         count = 1;
         while (!datapath.irWe && count < 20) begin
            nextCycle();
            count++;
            if (isLong && count == 5)
               checkMemExit(row.instr.opcode == controlPkg::LDW, i);
         end
         if (!datapath.irWe)
            stopRun($sformatf("timeout: row %0d never reached the next fetch", i));
         checkCount(count, row.spacing, $sformatf("row %0d irWe spacing", i));
         if (row.instr.opcode == controlPkg::CMP || row.instr.opcode == controlPkg::CMPI)
            carryWant = row.flags.c;                // loaded at the end of execute Cycle0
      end

      instr.opcode = controlPkg::ADD;
      nIrq = 1'b0;
      count = 0;
      do begin
         nextCycle();
         count++;
         if (count == 2)
            nIrq = 1'b1;                            // short pulse, one request only
      end while (!(datapath.pcSel == controlPkg::PcInt && datapath.pcWe) && count < 40);
      if (!(datapath.pcSel == controlPkg::PcInt && datapath.pcWe))
         stopRun("timeout: interrupt entry never loaded the interrupt vector");
      waitIrWe(count, 10, "after interrupt entry");
      checkCount(count, 4, "cycles from interrupt vector to irWe");
      extraEntries = 0;
      repeat (30) begin
         nextCycle();
         if (datapath.pcSel == controlPkg::PcInt && datapath.pcWe)
            extraEntries++;
      end
      checkCount(extraEntries, 0, "interrupt entries after nIrq release");
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== controlUnit.f ====
verilog/controlPkg.sv
verilog/irqSync.sv
verilog/statusFlags.sv
verilog/cycleSequencer.sv
verilog/controlDecoder.sv
verilog/controlUnit.sv
verification/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; a failing run exits nonzero
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f controlUnit.f \
   --top-module controlUnitTb -o controlUnitSim &&
./obj_dir/controlUnitSim || exit 1
